//--- Makefile
# Verilator build and run of the download-path testbench

TOP = tb_loader

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f $(wildcard *.sv *.svh)
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

//--- dl_index_decode.sv
//========================================
// Decode stage of the download path
// Registers the download kind for the packer
// and raises the ROM-copy command and the
// cartridge-loaded flag
//========================================
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module dl_index_decode
	import loader_pkg::*, memory_pkg::*;
(
	input  wire logic         clk_1x,
	input  wire logic         arst_n,
	input  wire host_stream_t host,
	output dl_ctrl_t          ctrl,
	output rom_copy_t         rom_copy,
	output logic              cart_loaded
);

	dl_kind_t    kind_q;
	logic        bank_q;
	logic        download_q;
	logic        n64_fall;
	logic        n64_end;
	logic        copy_start;
	sdram_addr_t copy_size;
	logic        loaded_q;

	// Falling download of a main cartridge
	assign n64_fall = download_q & ~host.download & (host.index[5:0] == IDX_N64);

	//========================================
	// Kind register
	//========================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			kind_q     <= DL_NONE;
			bank_q     <= 1'b0;
			download_q <= 1'b0;
		end else begin
			kind_q     <= host.download ? kind_of(host.index) : DL_NONE;
			bank_q     <= host.index[6];
			download_q <= host.download;
		end
	end

	//========================================
	// ROM copy and loaded flag
	//========================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			n64_end    <= 1'b0;
			copy_start <= 1'b0;
			loaded_q   <= 1'b0;
		end else begin
			n64_end    <= n64_fall;
			copy_start <= n64_end;
			// Sticky until reset
			if (kind_q == DL_N64)
				loaded_q <= 1'b1;
		end
	end

	// Last address is the file size
	always_ff @(posedge clk_1x) begin
		if (n64_fall)
			copy_size <= host.addr;
	end

	assign ctrl        = '{kind: kind_q, pif_bank: bank_q};
	assign rom_copy    = '{start: copy_start, size: copy_size};
	assign cart_loaded = loaded_q;

endmodule

`default_nettype wire

//--- dl_word_packer.sv
//========================================
// Execute stage of the download path
// Packs two host halfwords into one word
// per download kind and holds the host off
// while the SDRAM owns a word
//========================================
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module dl_word_packer
	import loader_pkg::*, memory_pkg::*;
(
	input  wire logic         clk_1x,
	input  wire logic         arst_n,
	input  wire host_stream_t host,
	input  wire dl_ctrl_t     ctrl,
	input  wire logic         ram_ready,
	output logic              ioctl_wait,
	output packed_word_t      word
);

	logic        word_valid;
	target_t     word_target;
	sdram_addr_t word_addr;
	word_t       word_data;
	logic        wait_q;
	logic        first_half;
	logic        second_half;
	pif_addr_t   pif_word_addr;

	// Address bit 1 picks the half of the word
	assign first_half  = host.wr & ~host.addr[1];
	assign second_half = host.wr & host.addr[1];

	// Boot-ROM word address with the bank on top
	assign pif_word_addr = {ctrl.pif_bank, host.addr[`LD_PIF_ADDR_W:2]};

	//========================================
	// Valid strobe and host wait
	//========================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			word_valid <= 1'b0;
			wait_q     <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			case (ctrl.kind)
				DL_PIF: begin
					wait_q <= 1'b0;
					if (second_half)
						word_valid <= 1'b1;
				end
				DL_GB: begin
					if (second_half) begin
						word_valid <= 1'b1;
						wait_q     <= 1'b1;
					end
					// SDRAM has taken the word
					if (ram_ready)
						wait_q <= 1'b0;
				end
				default: begin
					wait_q <= 1'b0;
				end
			endcase
		end
	end

	//========================================
	// Word assembly
	//========================================
	always_ff @(posedge clk_1x) begin
		case (ctrl.kind)
			DL_PIF: begin
				// Boot ROM is stored byte swapped
				if (first_half) begin
					word_data[31:24] <= host.data[7:0];
					word_data[23:16] <= host.data[15:8];
					word_addr        <= sdram_addr_t'(pif_word_addr);
				end
				if (second_half) begin
					word_data[15:8] <= host.data[7:0];
					word_data[7:0]  <= host.data[15:8];
					word_target     <= TGT_PIF;
				end
			end
			DL_GB: begin
				if (first_half) begin
					word_data[15:0] <= host.data;
					word_addr       <= host.addr + dl_addr_t'(`LD_GB_BASE);
				end
				if (second_half) begin
					word_data[31:16] <= host.data;
					word_target      <= TGT_RAM;
				end
			end
			default: begin
			end
		endcase
	end

	assign word = '{valid: word_valid, target: word_target, addr: word_addr, data: word_data};
	assign ioctl_wait = wait_q;

endmodule

`default_nettype wire

//--- dl_write_port.sv
//========================================
// Result stage of the download path
// Turns each packed word into a one-cycle
// boot-ROM write or SDRAM request
//========================================
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module dl_write_port
	import memory_pkg::*;
(
	input  wire logic         clk_1x,
	input  wire logic         arst_n,
	input  wire packed_word_t word,
	output pif_wr_t           pif_wr,
	output ram_wr_t           ram_wr
);

	logic        pif_wren;
	pif_addr_t   pif_addr;
	word_t       pif_data;
	logic        ram_req;
	sdram_addr_t ram_addr;
	word_t       ram_data;

	// Strobes, one cycle per word
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			pif_wren <= 1'b0;
			ram_req  <= 1'b0;
		end else begin
			pif_wren <= word.valid & (word.target == TGT_PIF);
			ram_req  <= word.valid & (word.target == TGT_RAM);
		end
	end

	// Address and data hold between strobes
	always_ff @(posedge clk_1x) begin
		if (word.valid) begin
			if (word.target == TGT_PIF) begin
				pif_addr <= word.addr[`LD_PIF_ADDR_W-1:0];
				pif_data <= word.data;
			end else begin
				ram_addr <= word.addr;
				ram_data <= word.data;
			end
		end
	end

	assign pif_wr = '{wren: pif_wren, addr: pif_addr, data: pif_data};
	assign ram_wr = '{req: ram_req, addr: ram_addr, data: ram_data};

endmodule

`default_nettype wire

//--- files.f
+incdir+.
loader_pkg.sv
memory_pkg.sv
dl_index_decode.sv
dl_word_packer.sv
dl_write_port.sv
n64_loader_top.sv
tb_loader.sv

//--- loader_params.svh
//========================================
// Constants of the file-download path
// Include where a file index, the cartridge
// base or an address width is needed
//========================================
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// Host file indices, low six bits
`define LD_IDX_PIF 0
`define LD_IDX_N64 1
`define LD_IDX_GB 2

// SDRAM byte base of handheld cartridge words
`define LD_GB_BASE 8388608

// Address widths
`define LD_ADDR_W 27
`define LD_PIF_ADDR_W 10

`endif

//--- loader_pkg.sv
//========================================
// Host side of the download path
// Stream types, the decoded download kind
// and the index classifier
//========================================
`default_nettype none

`include "loader_params.svh"

package loader_pkg;

	typedef logic [15:0] halfword_t;
	typedef logic [`LD_ADDR_W-1:0] dl_addr_t;
	typedef logic [7:0] dl_index_t;

	// State of the download-kind register
	typedef enum logic [1:0] {
		DL_NONE,
		DL_PIF,
		DL_N64,
		DL_GB
	} dl_kind_t;

	// One beat from the host
	typedef struct packed {
		logic      download;
		dl_index_t index;
		dl_addr_t  addr;
		halfword_t data;
		logic      wr;
	} host_stream_t;

	// Decode stage to packer, pif_bank is index bit 6
	typedef struct packed {
		dl_kind_t kind;
		logic     pif_bank;
	} dl_ctrl_t;

	localparam logic [5:0] IDX_PIF = 6'(`LD_IDX_PIF);
	localparam logic [5:0] IDX_N64 = 6'(`LD_IDX_N64);
	localparam logic [5:0] IDX_GB  = 6'(`LD_IDX_GB);

	// Only the low six index bits select the file type
	function automatic dl_kind_t kind_of(input dl_index_t index);
		dl_kind_t kind;
		case (index[5:0])
			IDX_PIF: kind = DL_PIF;
			IDX_N64: kind = DL_N64;
			IDX_GB:  kind = DL_GB;
			default: kind = DL_NONE;
		endcase
		return kind;
	endfunction

endpackage

`default_nettype wire

//--- memory_pkg.sv
//========================================
// Memory side of the download path
// Packed words, the boot-ROM and SDRAM
// write ports and the ROM-copy command
//========================================
`default_nettype none

`include "loader_params.svh"

package memory_pkg;

	typedef logic [31:0] word_t;
	typedef logic [`LD_PIF_ADDR_W-1:0] pif_addr_t;
	typedef logic [`LD_ADDR_W-1:0] sdram_addr_t;

	// Destination of a packed word
	typedef enum logic {
		TGT_PIF,
		TGT_RAM
	} target_t;

	// addr is already the final word or byte address
	typedef struct packed {
		logic        valid;
		target_t     target;
		sdram_addr_t addr;
		word_t       data;
	} packed_word_t;

	typedef struct packed {
		logic      wren;
		pif_addr_t addr;
		word_t     data;
	} pif_wr_t;

	typedef struct packed {
		logic        req;
		sdram_addr_t addr;
		word_t       data;
	} ram_wr_t;

	typedef struct packed {
		logic        start;
		sdram_addr_t size;
	} rom_copy_t;

endpackage

`default_nettype wire

//--- n64_loader_top.sv
//========================================
// File-download path of the console top
// Host stream in, boot-ROM writes and
// SDRAM requests out, plus the ROM-copy
// command for a main cartridge
//========================================
`timescale 1ns/1ps
`default_nettype none

module n64_loader_top
	import loader_pkg::*, memory_pkg::*;
(
	input  wire logic         clk_1x,
	input  wire logic         arst_n,
	input  wire host_stream_t host,
	output logic              ioctl_wait,
	output pif_wr_t           pif_wr,
	output ram_wr_t           ram_wr,
	input  wire logic         ram_ready,
	output rom_copy_t         rom_copy,
	output logic              cart_loaded
);

	dl_ctrl_t     ctrl;
	packed_word_t word;

	//========================================
	// Decode
	//========================================
	dl_index_decode dl_index_decode_i (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.host        (host),
		.ctrl        (ctrl),
		.rom_copy    (rom_copy),
		.cart_loaded (cart_loaded)
	);

	//========================================
	// Execute
	//========================================
	dl_word_packer dl_word_packer_i (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.host       (host),
		.ctrl       (ctrl),
		.ram_ready  (ram_ready),
		.ioctl_wait (ioctl_wait),
		.word       (word)
	);

	//========================================
	// Result
	//========================================
	dl_write_port dl_write_port_i (
		.clk_1x (clk_1x),
		.arst_n (arst_n),
		.word   (word),
		.pif_wr (pif_wr),
		.ram_wr (ram_wr)
	);

endmodule

`default_nettype wire

//--- tb_loader.sv
//========================================
// Testbench of the download path
// Drives host files, answers SDRAM requests
// and checks every write against a model
//========================================
`timescale 1ns/1ps
`default_nettype none

`include "loader_params.svh"

module tb_loader
	import loader_pkg::*, memory_pkg::*;
();

	typedef struct packed {
		word_t       data;
		sdram_addr_t addr;
		logic [31:0] due;
	} expected_t;

	localparam int TIMEOUT = 50;

	logic         clk_1x = 1'b0;
	logic         arst_n;
	host_stream_t host;
	logic         ram_ready = 1'b0;
	logic         ioctl_wait;
	pif_wr_t      pif_wr;
	ram_wr_t      ram_wr;
	rom_copy_t    rom_copy;
	logic         cart_loaded;

	integer       seed = 32'h2a270d78;
	int           cyc = 0;
	int           copy_count = 0;
	sdram_addr_t  copy_size;
	logic         responder_on;
	expected_t    pif_queue[$];
	expected_t    ram_queue[$];

	n64_loader_top n64_loader_top_i (.*);

	always #50 clk_1x = ~clk_1x;

	always @(posedge clk_1x) cyc <= cyc + 1;

	//========================================
	// Checking helpers
	//========================================
	task automatic abort_run(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "simulation stopped");
		end
	endtask

	// Expected word and address of one halfword pair
	function automatic expected_t reference_word(input halfword_t h0, input halfword_t h1,
		input dl_index_t index, input dl_addr_t start);
		expected_t e;
		e.due = '0;
		if (index[5:0] == 6'(`LD_IDX_PIF)) begin
			// Bytes swapped, bank bit above the word address
			e.data = {h0[7:0], h0[15:8], h1[7:0], h1[15:8]};
			e.addr = sdram_addr_t'({index[6], start[10:2]});
		end else begin
			e.data = {h1, h0};
			e.addr = start + sdram_addr_t'(`LD_GB_BASE);
		end
		return e;
	endfunction

	//========================================
	// Host driver
	//========================================
	task automatic wait_host_ready();
		int waited;
		waited = 0;
		while (ioctl_wait) begin
			@(posedge clk_1x);
			#1;
			waited++;
			if (waited > TIMEOUT)
				abort_run("host wait flag never fell");
		end
	endtask

	task automatic host_write(input dl_addr_t addr, input halfword_t data, output int drive_cyc);
		wait_host_ready();
		host.addr = addr;
		host.data = data;
		host.wr   = 1'b1;
		drive_cyc = cyc;
		@(posedge clk_1x);
		#1;
		host.wr = 1'b0;
	endtask

	task automatic send_word(input dl_addr_t start);
		logic [31:0] rnd;
		expected_t   e;
		int          drive_cyc;
		rnd = $random(seed);
		e = reference_word(rnd[15:0], rnd[31:16], host.index, start);
		host_write(start, rnd[15:0], drive_cyc);
		@(posedge clk_1x);
		#1;
		host_write(start + 27'd2, rnd[31:16], drive_cyc);
		// Strobe two edges after the second half is driven
		e.due = drive_cyc + 2;
		case (host.index[5:0])
			6'(`LD_IDX_PIF): pif_queue.push_back(e);
			6'(`LD_IDX_GB): begin
				ram_queue.push_back(e);
				check_equal(64'(ioctl_wait), 64'd1, "ioctl_wait after cartridge word");
			end
			default: check_equal(64'(ioctl_wait), 64'd0, "ioctl_wait outside cartridge");
		endcase
		@(posedge clk_1x);
		#1;
	endtask

	task automatic send_file(input dl_index_t index, input int words);
		host.index    = index;
		host.download = 1'b1;
		repeat (2) @(posedge clk_1x);
		#1;
		for (int i = 0; i < words; i++)
			send_word(dl_addr_t'(i * 4));
	endtask

	task automatic end_download();
		host.download = 1'b0;
		repeat (3) @(posedge clk_1x);
		#1;
	endtask

	//========================================
	// Monitor and SDRAM responder
	//========================================
	always @(negedge clk_1x) begin : monitor
		expected_t head;
		if (pif_wr.wren) begin
			if (pif_queue.size() == 0)
				abort_run("boot-ROM write with none expected");
			else begin
				head = pif_queue.pop_front();
				check_equal(64'(pif_wr.addr), 64'(head.addr), "boot-ROM address");
				check_equal(64'(pif_wr.data), 64'(head.data), "boot-ROM data");
				check_equal(64'(cyc), 64'(head.due), "boot-ROM write latency");
			end
		end
		if (ram_wr.req) begin
			if (ram_queue.size() == 0)
				abort_run("SDRAM request with none expected");
			else begin
				head = ram_queue.pop_front();
				check_equal(64'(ram_wr.addr), 64'(head.addr), "SDRAM address");
				check_equal(64'(ram_wr.data), 64'(head.data), "SDRAM data");
				check_equal(64'(cyc), 64'(head.due), "SDRAM request latency");
			end
		end
		if (rom_copy.start) begin
			copy_count++;
			copy_size = rom_copy.size;
		end
	end

	always @(negedge clk_1x) begin : sdram_responder
		int delay;
		if (ram_wr.req && responder_on) begin
			delay = 1 + int'($unsigned($random(seed)) % 6);
			repeat (delay) begin
				@(posedge clk_1x);
				#1;
				check_equal(64'(ioctl_wait), 64'd1, "ioctl_wait while SDRAM busy");
			end
			ram_ready = 1'b1;
			@(posedge clk_1x);
			#1;
			ram_ready = 1'b0;
			check_equal(64'(ioctl_wait), 64'd0, "ioctl_wait after ram_ready");
		end
	end

	//========================================
	// Main sequence
	//========================================
	initial begin : main
		int drop_cyc;
		host         = '0;
		responder_on = 1'b1;
		arst_n       = 1'b0;
		repeat (2) @(posedge clk_1x);
		#1;
		arst_n = 1'b1;
		repeat (4) begin
			@(negedge clk_1x);
			check_equal(64'({pif_wr.wren, ram_wr.req, ioctl_wait, rom_copy.start, cart_loaded}),
				64'd0, "idle outputs after reset");
		end
		@(posedge clk_1x);
		#1;
		// Boot ROM, both banks
		send_file(8'd0, 64);
		end_download();
		send_file(8'd64, 64);
		end_download();
		// Handheld cartridge through the SDRAM
		send_file(8'd2, 32);
		wait_host_ready();
		end_download();
		check_equal(64'(cart_loaded), 64'd0, "cart_loaded before main cartridge");
		// Main cartridge, ROM copy at the end
		send_file(8'd1, 16);
		end_download();
		repeat (4) @(posedge clk_1x);
		#1;
		check_equal(64'(copy_count), 64'd1, "ROM-copy start pulses");
		check_equal(64'(copy_size), 64'd62, "ROM-copy size");
		check_equal(64'(cart_loaded), 64'd1, "cart_loaded after main cartridge");
		// Unknown file type
		send_file(8'd5, 8);
		end_download();
		// Cartridge cut short while the SDRAM still owns the word
		responder_on = 1'b0;
		send_file(8'd2, 1);
		check_equal(64'(ioctl_wait), 64'd1, "ioctl_wait before early end");
		host.download = 1'b0;
		drop_cyc = cyc;
		wait_host_ready();
		// Kind clears one edge later and the wait one edge after that
		check_equal(64'(cyc - drop_cyc), 64'd2, "ioctl_wait fall after early end");
		repeat (4) @(posedge clk_1x);
		#1;
		check_equal(64'(copy_count), 64'd1, "ROM-copy start pulses at end");
		check_equal(64'(cart_loaded), 64'd1, "cart_loaded at end");
		if (pif_queue.size() != 0 || ram_queue.size() != 0)
			abort_run("expected writes never appeared");
		else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
